/* src/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  prot_t;

    // AXI4-Lite response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_t;

    // arbiter grant states
    typedef enum logic [1:0] {
        grant_idle = 2'b00,
        grant_inst = 2'b01,
        grant_mem  = 2'b10
    } grant_e;

endpackage

`default_nettype wire

/* src/axi_lite_if.sv */
`default_nettype none

interface axi_lite_if;
    import soc_bus_pkg::*;

    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    prot_t awprot;

    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;

    logic  bvalid;
    logic  bready;
    resp_t bresp;

    logic  arvalid;
    logic  arready;
    addr_t araddr;
    prot_t arprot;

    logic  rvalid;
    logic  rready;
    data_t rdata;
    resp_t rresp;

    modport master (
        output awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, arprot, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, arprot, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

/* src/pmem_arbiter.sv */
`default_nettype none

module pmem_arbiter (
    input wire          aclk,
    input wire          areset_n,
    input wire          inst_fetch_flag,
    input wire          mem_access_flag,
    axi_lite_if.slave   ifu,
    axi_lite_if.slave   lsu,
    axi_lite_if.master  shared
);
    import soc_bus_pkg::*;

    grant_e state;
    logic   busy;
    logic   addr_hs;
    logic   resp_hs;
    logic   ifu_sel;
    logic   lsu_sel;

    assign addr_hs = (shared.awvalid & shared.awready) | (shared.arvalid & shared.arready);
    assign resp_hs = (shared.bvalid & shared.bready) | (shared.rvalid & shared.rready);

    // one transaction outstanding at a time
    always_ff @(posedge aclk) begin
        if (areset_n) begin
            busy <= 1'b0;
        end else if (addr_hs) begin
            busy <= 1'b1;
        end else if (resp_hs) begin
            busy <= 1'b0;
        end
    end

    // grant moves only between transactions
    always_ff @(posedge aclk) begin
        if (areset_n) begin
            state <= grant_idle;
        end else if (!busy && !addr_hs) begin
            case (state)
                grant_idle: state <= grant_inst;
                grant_inst: if (mem_access_flag) state <= grant_mem;
                grant_mem:  if (inst_fetch_flag) state <= grant_inst;
                default:    state <= grant_idle;
            endcase
        end
    end

    assign ifu_sel = (state == grant_inst);
    assign lsu_sel = (state == grant_mem);

    // write channels belong to the lsu alone
    assign shared.awvalid = lsu_sel & lsu.awvalid;
    assign shared.awaddr  = lsu.awaddr;
    assign shared.awprot  = lsu.awprot;
    assign shared.wvalid  = lsu_sel & lsu.wvalid;
    assign shared.wdata   = lsu.wdata;
    assign shared.wstrb   = lsu.wstrb;
    assign shared.bready  = lsu_sel & lsu.bready;

    assign shared.arvalid = ifu_sel ? ifu.arvalid : (lsu_sel & lsu.arvalid);
    assign shared.araddr  = ifu_sel ? ifu.araddr  : lsu.araddr;
    assign shared.arprot  = ifu_sel ? ifu.arprot  : lsu.arprot;
    assign shared.rready  = ifu_sel ? ifu.rready  : (lsu_sel & lsu.rready);

    assign lsu.awready = lsu_sel & shared.awready;
    assign lsu.wready  = lsu_sel & shared.wready;
    assign lsu.bvalid  = lsu_sel & shared.bvalid;
    assign lsu.bresp   = shared.bresp;
    assign lsu.arready = lsu_sel & shared.arready;
    assign lsu.rvalid  = lsu_sel & shared.rvalid;
    assign lsu.rdata   = shared.rdata;
    assign lsu.rresp   = shared.rresp;

    // ifu never writes
    assign ifu.awready = 1'b0;
    assign ifu.wready  = 1'b0;
    assign ifu.bvalid  = 1'b0;
    assign ifu.bresp   = resp_okay;
    assign ifu.arready = ifu_sel & shared.arready;
    assign ifu.rvalid  = ifu_sel & shared.rvalid;
    assign ifu.rdata   = shared.rdata;
    assign ifu.rresp   = shared.rresp;

endmodule

`default_nettype wire

/* src/mmio_xbar.sv */
`default_nettype none

module mmio_xbar #(
    parameter soc_bus_pkg::addr_t pmem_base  = 32'h8000_0000,
    parameter soc_bus_pkg::addr_t pmem_size  = 32'h1000,
    parameter soc_bus_pkg::addr_t uart_base  = 32'ha000_03f8,
    parameter soc_bus_pkg::addr_t uart_size  = 32'h8,
    parameter soc_bus_pkg::addr_t clint_base = 32'ha000_0048,
    parameter soc_bus_pkg::addr_t clint_size = 32'h8
) (
    input wire          aclk,
    input wire          areset_n,
    axi_lite_if.slave   up,
    axi_lite_if.master  pmem,
    axi_lite_if.master  uart,
    axi_lite_if.master  clint
);
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {route_pmem, route_uart, route_clint, route_err} route_e;

    function automatic logic in_window(addr_t a, addr_t base, addr_t size);
        return (a >= base) && ((a - base) < size);
    endfunction

    logic   is_write;
    addr_t  addr;
    route_e dec_route;
    route_e route_q;
    logic   active;
    logic   addr_hs;
    logic   resp_hs;
    logic   sel_pmem;
    logic   sel_uart;
    logic   sel_clint;
    logic   err_bvalid;
    logic   err_rvalid;

    // write address wins over a read presented at the same time
    assign is_write = up.awvalid;
    assign addr     = is_write ? up.awaddr : up.araddr;

    always_comb begin
        if (in_window(addr, pmem_base, pmem_size)) begin
            dec_route = route_pmem;
        end else if (in_window(addr, uart_base, uart_size) && is_write) begin
            dec_route = route_uart;
        end else if (in_window(addr, clint_base, clint_size) && !is_write) begin
            dec_route = route_clint;
        end else begin
            dec_route = route_err;
        end
    end

    assign addr_hs = (up.awvalid & up.awready) | (up.arvalid & up.arready);
    assign resp_hs = (up.bvalid & up.bready) | (up.rvalid & up.rready);

    // route held from address handshake to response handshake
    always_ff @(posedge aclk) begin
        if (areset_n) begin
            active  <= 1'b0;
            route_q <= route_err;
        end else if (addr_hs) begin
            active  <= 1'b1;
            route_q <= dec_route;
        end else if (resp_hs) begin
            active  <= 1'b0;
        end
    end

    // decode error responder
    always_ff @(posedge aclk) begin
        if (areset_n) begin
            err_bvalid <= 1'b0;
            err_rvalid <= 1'b0;
        end else if (addr_hs && dec_route == route_err) begin
            err_bvalid <= is_write;
            err_rvalid <= !is_write;
        end else begin
            if (up.bready) err_bvalid <= 1'b0;
            if (up.rready) err_rvalid <= 1'b0;
        end
    end

    assign sel_pmem  = !active && dec_route == route_pmem;
    assign sel_uart  = !active && dec_route == route_uart;
    assign sel_clint = !active && dec_route == route_clint;

    assign pmem.awvalid  = up.awvalid & sel_pmem;
    assign pmem.awaddr   = up.awaddr;
    assign pmem.awprot   = up.awprot;
    assign pmem.wvalid   = up.wvalid & sel_pmem;
    assign pmem.wdata    = up.wdata;
    assign pmem.wstrb    = up.wstrb;
    assign pmem.bready   = up.bready & (route_q == route_pmem);
    assign pmem.arvalid  = up.arvalid & !is_write & sel_pmem;
    assign pmem.araddr   = up.araddr;
    assign pmem.arprot   = up.arprot;
    assign pmem.rready   = up.rready & (route_q == route_pmem);

    assign uart.awvalid  = up.awvalid & sel_uart;
    assign uart.awaddr   = up.awaddr;
    assign uart.awprot   = up.awprot;
    assign uart.wvalid   = up.wvalid & sel_uart;
    assign uart.wdata    = up.wdata;
    assign uart.wstrb    = up.wstrb;
    assign uart.bready   = up.bready & (route_q == route_uart);
    assign uart.arvalid  = 1'b0;
    assign uart.araddr   = up.araddr;
    assign uart.arprot   = up.arprot;
    assign uart.rready   = 1'b0;

    // clint only ever sees reads
    assign clint.awvalid = 1'b0;
    assign clint.awaddr  = up.awaddr;
    assign clint.awprot  = up.awprot;
    assign clint.wvalid  = 1'b0;
    assign clint.wdata   = up.wdata;
    assign clint.wstrb   = up.wstrb;
    assign clint.bready  = 1'b0;
    assign clint.arvalid = up.arvalid & !is_write & sel_clint;
    assign clint.araddr  = up.araddr;
    assign clint.arprot  = up.arprot;
    assign clint.rready  = up.rready & (route_q == route_clint);

    always_comb begin
        up.awready = 1'b0;
        up.wready  = 1'b0;
        up.arready = 1'b0;
        if (!active) begin
            case (dec_route)
                route_pmem: begin
                    up.awready = is_write & pmem.awready;
                    up.wready  = is_write & pmem.wready;
                    up.arready = !is_write & pmem.arready;
                end
                route_uart: begin
                    up.awready = uart.awready;
                    up.wready  = uart.wready;
                end
                route_clint: up.arready = clint.arready;
                default: begin
                    up.awready = is_write;
                    up.wready  = is_write;
                    up.arready = !is_write;
                end
            endcase
        end
    end

    always_comb begin
        up.bvalid = err_bvalid;
        up.bresp  = resp_decerr;
        up.rvalid = err_rvalid;
        up.rdata  = '0;
        up.rresp  = resp_decerr;
        case (route_q)
            route_pmem: begin
                up.bvalid = pmem.bvalid;
                up.bresp  = pmem.bresp;
                up.rvalid = pmem.rvalid;
                up.rdata  = pmem.rdata;
                up.rresp  = pmem.rresp;
            end
            route_uart: begin
                up.bvalid = uart.bvalid;
                up.bresp  = uart.bresp;
            end
            route_clint: begin
                up.rvalid = clint.rvalid;
                up.rdata  = clint.rdata;
                up.rresp  = clint.rresp;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/pmem_ram.sv */
`default_nettype none

module pmem_ram #(
    parameter soc_bus_pkg::addr_t pmem_size = 32'h1000
) (
    input wire          aclk,
    input wire          areset_n,
    axi_lite_if.slave   bus
);
    import soc_bus_pkg::*;

    localparam int unsigned pmem_words = pmem_size / 4;
    localparam int unsigned idx_w      = $clog2(pmem_words);

    data_t mem [pmem_words] = '{default: '0};

    logic  rvalid_q;
    logic  bvalid_q;
    data_t rdata_q;
    logic  busy;
    logic  wr_hs;
    logic  rd_hs;
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;

    assign busy   = rvalid_q | bvalid_q;
    assign wr_hs  = bus.awvalid & bus.wvalid & !busy;
    assign rd_hs  = bus.arvalid & !busy;
    assign wr_idx = bus.awaddr[idx_w+1:2];
    assign rd_idx = bus.araddr[idx_w+1:2];

    assign bus.awready = !busy;
    assign bus.wready  = !busy;
    assign bus.arready = !busy;
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = resp_okay;
    assign bus.rvalid  = rvalid_q;
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = resp_okay;

    // byte lanes merged under strobe
    always_ff @(posedge aclk) begin
        if (wr_hs) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.wstrb[b]) mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
        if (rd_hs) rdata_q <= mem[rd_idx];
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (rd_hs) rvalid_q <= 1'b1;
            else if (bus.rready) rvalid_q <= 1'b0;
            if (wr_hs) bvalid_q <= 1'b1;
            else if (bus.bready) bvalid_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/uart_tx_reg.sv */
`default_nettype none

module uart_tx_reg (
    input wire          aclk,
    input wire          areset_n,
    axi_lite_if.slave   bus,
    output logic        tx_valid,
    output logic [7:0]  tx_data
);
    import soc_bus_pkg::*;

    logic bvalid_q;
    logic wr_hs;

    assign wr_hs = bus.awvalid & bus.wvalid & !bvalid_q;

    assign bus.awready = !bvalid_q;
    assign bus.wready  = !bvalid_q;
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = resp_okay;
    // no read side
    assign bus.arready = 1'b0;
    assign bus.rvalid  = 1'b0;
    assign bus.rdata   = '0;
    assign bus.rresp   = resp_okay;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            bvalid_q <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            // pulse lines up with the rise of bvalid
            tx_valid <= wr_hs;
            if (wr_hs) bvalid_q <= 1'b1;
            else if (bus.bready) bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_hs) tx_data <= bus.wdata[7:0];
    end

endmodule

`default_nettype wire

/* src/clint_timer.sv */
`default_nettype none

module clint_timer (
    input wire          aclk,
    input wire          areset_n,
    axi_lite_if.slave   bus
);
    import soc_bus_pkg::*;

    logic [63:0] mtime;
    logic        rvalid_q;
    data_t       rdata_q;
    logic        rd_hs;

    assign rd_hs = bus.arvalid & !rvalid_q;

    assign bus.arready = !rvalid_q;
    assign bus.rvalid  = rvalid_q;
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = resp_okay;
    // read only
    assign bus.awready = 1'b0;
    assign bus.wready  = 1'b0;
    assign bus.bvalid  = 1'b0;
    assign bus.bresp   = resp_okay;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            mtime    <= '0;
            rvalid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (rd_hs) rvalid_q <= 1'b1;
            else if (bus.rready) rvalid_q <= 1'b0;
        end
    end

    // offset 4 selects the upper word
    always_ff @(posedge aclk) begin
        if (rd_hs) rdata_q <= bus.araddr[2] ? mtime[63:32] : mtime[31:0];
    end

endmodule

`default_nettype wire

/* src/soc_mem_top.sv */
`default_nettype none

module soc_mem_top #(
    parameter soc_bus_pkg::addr_t pmem_base  = 32'h8000_0000,
    parameter soc_bus_pkg::addr_t pmem_size  = 32'h1000,
    parameter soc_bus_pkg::addr_t uart_base  = 32'ha000_03f8,
    parameter soc_bus_pkg::addr_t uart_size  = 32'h8,
    parameter soc_bus_pkg::addr_t clint_base = 32'ha000_0048,
    parameter soc_bus_pkg::addr_t clint_size = 32'h8
) (
    input wire                       aclk,
    input wire                       areset_n,
    input wire                       inst_fetch_flag,
    input wire                       mem_access_flag,

    input wire                       ifu_arvalid,
    output logic                     ifu_arready,
    input wire soc_bus_pkg::addr_t   ifu_araddr,
    input wire soc_bus_pkg::prot_t   ifu_arprot,
    output logic                     ifu_rvalid,
    input wire                       ifu_rready,
    output soc_bus_pkg::data_t       ifu_rdata,
    output soc_bus_pkg::resp_t       ifu_rresp,

    input wire                       lsu_awvalid,
    output logic                     lsu_awready,
    input wire soc_bus_pkg::addr_t   lsu_awaddr,
    input wire soc_bus_pkg::prot_t   lsu_awprot,
    input wire                       lsu_wvalid,
    output logic                     lsu_wready,
    input wire soc_bus_pkg::data_t   lsu_wdata,
    input wire soc_bus_pkg::strb_t   lsu_wstrb,
    output logic                     lsu_bvalid,
    input wire                       lsu_bready,
    output soc_bus_pkg::resp_t       lsu_bresp,
    input wire                       lsu_arvalid,
    output logic                     lsu_arready,
    input wire soc_bus_pkg::addr_t   lsu_araddr,
    input wire soc_bus_pkg::prot_t   lsu_arprot,
    output logic                     lsu_rvalid,
    input wire                       lsu_rready,
    output soc_bus_pkg::data_t       lsu_rdata,
    output soc_bus_pkg::resp_t       lsu_rresp,

    output logic                     uart_tx_valid,
    output logic [7:0]               uart_tx_data
);

    axi_lite_if ifu_bus ();
    axi_lite_if lsu_bus ();
    axi_lite_if shared_bus ();
    axi_lite_if pmem_bus ();
    axi_lite_if uart_bus ();
    axi_lite_if clint_bus ();

    // ifu has no write channels
    assign ifu_bus.awvalid = 1'b0;
    assign ifu_bus.awaddr  = '0;
    assign ifu_bus.awprot  = '0;
    assign ifu_bus.wvalid  = 1'b0;
    assign ifu_bus.wdata   = '0;
    assign ifu_bus.wstrb   = '0;
    assign ifu_bus.bready  = 1'b0;
    assign ifu_bus.arvalid = ifu_arvalid;
    assign ifu_bus.araddr  = ifu_araddr;
    assign ifu_bus.arprot  = ifu_arprot;
    assign ifu_bus.rready  = ifu_rready;
    assign ifu_arready     = ifu_bus.arready;
    assign ifu_rvalid      = ifu_bus.rvalid;
    assign ifu_rdata       = ifu_bus.rdata;
    assign ifu_rresp       = ifu_bus.rresp;

    assign lsu_bus.awvalid = lsu_awvalid;
    assign lsu_bus.awaddr  = lsu_awaddr;
    assign lsu_bus.awprot  = lsu_awprot;
    assign lsu_bus.wvalid  = lsu_wvalid;
    assign lsu_bus.wdata   = lsu_wdata;
    assign lsu_bus.wstrb   = lsu_wstrb;
    assign lsu_bus.bready  = lsu_bready;
    assign lsu_bus.arvalid = lsu_arvalid;
    assign lsu_bus.araddr  = lsu_araddr;
    assign lsu_bus.arprot  = lsu_arprot;
    assign lsu_bus.rready  = lsu_rready;
    assign lsu_awready     = lsu_bus.awready;
    assign lsu_wready      = lsu_bus.wready;
    assign lsu_bvalid      = lsu_bus.bvalid;
    assign lsu_bresp       = lsu_bus.bresp;
    assign lsu_arready     = lsu_bus.arready;
    assign lsu_rvalid      = lsu_bus.rvalid;
    assign lsu_rdata       = lsu_bus.rdata;
    assign lsu_rresp       = lsu_bus.rresp;

    pmem_arbiter u_pmem_arbiter (
        .aclk            (aclk),
        .areset_n        (areset_n),
        .inst_fetch_flag (inst_fetch_flag),
        .mem_access_flag (mem_access_flag),
        .ifu             (ifu_bus),
        .lsu             (lsu_bus),
        .shared          (shared_bus)
    );

    mmio_xbar #(
        .pmem_base  (pmem_base),
        .pmem_size  (pmem_size),
        .uart_base  (uart_base),
        .uart_size  (uart_size),
        .clint_base (clint_base),
        .clint_size (clint_size)
    ) u_mmio_xbar (
        .aclk     (aclk),
        .areset_n (areset_n),
        .up       (shared_bus),
        .pmem     (pmem_bus),
        .uart     (uart_bus),
        .clint    (clint_bus)
    );

    pmem_ram #(
        .pmem_size (pmem_size)
    ) u_pmem_ram (
        .aclk     (aclk),
        .areset_n (areset_n),
        .bus      (pmem_bus)
    );

    uart_tx_reg u_uart_tx_reg (
        .aclk     (aclk),
        .areset_n (areset_n),
        .bus      (uart_bus),
        .tx_valid (uart_tx_valid),
        .tx_data  (uart_tx_data)
    );

    clint_timer u_clint_timer (
        .aclk     (aclk),
        .areset_n (areset_n),
        .bus      (clint_bus)
    );

endmodule

`default_nettype wire

/* tb/soc_mem_chk.sv */
`default_nettype none

module soc_mem_chk (
    input wire                     aclk,
    input wire                     areset_n,
    input wire                     ifu_arready,
    input wire                     lsu_arready,
    input wire                     ifu_rvalid,
    input wire                     ifu_rready,
    input wire soc_bus_pkg::data_t ifu_rdata,
    input wire soc_bus_pkg::resp_t ifu_rresp,
    input wire                     lsu_rvalid,
    input wire                     lsu_rready,
    input wire soc_bus_pkg::data_t lsu_rdata,
    input wire soc_bus_pkg::resp_t lsu_rresp,
    input wire                     lsu_bvalid,
    input wire                     uart_tx_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // only one master may be granted the read address channel
    a_arready_exclusive: assert property (@(posedge aclk) !(ifu_arready && lsu_arready))
        else $error("ifu and lsu both see arready");

    a_ifu_r_stable: assert property (@(posedge aclk) disable iff (areset_n)
        ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rresp))
        else $error("ifu read response changed before rready");

    a_lsu_r_stable: assert property (@(posedge aclk) disable iff (areset_n)
        lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata) && $stable(lsu_rresp))
        else $error("lsu read response changed before rready");

    a_uart_single_pulse: assert property (@(posedge aclk) disable iff (areset_n)
        uart_tx_valid |=> !uart_tx_valid)
        else $error("uart_tx_valid high for two cycles");

    // reset is active high
    a_reset_quiet: assert property (@(posedge aclk)
        areset_n && $past(areset_n) |-> !ifu_rvalid && !lsu_rvalid && !lsu_bvalid
            && !uart_tx_valid)
        else $error("valid toward the core high during reset");

endmodule

bind soc_mem_top soc_mem_chk u_soc_mem_chk (.*);

`default_nettype wire

/* tb/tb_soc_mem.sv */
`default_nettype none

module tb_soc_mem;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_bus_pkg::*;

    localparam addr_t pmem_base = 32'h8000_0000;
    localparam addr_t pmem_size = 32'h1000;
    localparam addr_t uart_base = 32'ha000_03f8;

    logic  aclk = 1'b0;
    logic  areset_n;
    logic  inst_fetch_flag;
    logic  mem_access_flag;
    logic  ifu_arvalid;
    logic  ifu_arready;
    addr_t ifu_araddr;
    prot_t ifu_arprot;
    logic  ifu_rvalid;
    logic  ifu_rready;
    data_t ifu_rdata;
    resp_t ifu_rresp;
    logic  lsu_awvalid;
    logic  lsu_awready;
    addr_t lsu_awaddr;
    prot_t lsu_awprot;
    logic  lsu_wvalid;
    logic  lsu_wready;
    data_t lsu_wdata;
    strb_t lsu_wstrb;
    logic  lsu_bvalid;
    logic  lsu_bready;
    resp_t lsu_bresp;
    logic  lsu_arvalid;
    logic  lsu_arready;
    addr_t lsu_araddr;
    prot_t lsu_arprot;
    logic  lsu_rvalid;
    logic  lsu_rready;
    data_t lsu_rdata;
    resp_t lsu_rresp;
    logic  uart_tx_valid;
    logic [7:0] uart_tx_data;

    // golden records
    logic [23:0]     rec_master [$];
    logic [15:0]     rec_op [$];
    addr_t           rec_addr [$];
    data_t           rec_wdata [$];
    strb_t           rec_strb [$];
    data_t           rec_rdata [$];
    logic [1:0]      rec_resp [$];
    logic [8*24-1:0] rec_name [$];

    data_t       model [1024] = '{default: '0};
    logic [31:0] lcg_state = 32'h640a_e7e8;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          cycle_limit = 100;
    int          uart_pulses = 0;
    logic [7:0]  uart_last = 8'd0;
    logic        on_lsu = 1'b0;
    data_t       last_timer = '0;

    soc_mem_top u_soc_mem_top (.*);

    always #20 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(negedge aclk) begin
        if (uart_tx_valid) begin
            uart_pulses = uart_pulses + 1;
            uart_last = uart_tx_data;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [8*24-1:0] name, input data_t expected,
                               input data_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %0s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic load_golden();
        int fd;
        int n;
        string line;
        logic [23:0] m;
        logic [15:0] o;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] r;
        logic [31:0] p;
        logic [8*24-1:0] nm;
        fd = $fopen("tb/soc_mem_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file tb/soc_mem_golden.txt could not be opened");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h %h %h %h %s", m, o, a, d, s, r, p, nm);
                // comment and blank lines do not parse to eight fields
                if (n == 8) begin
                    rec_master.push_back(m);
                    rec_op.push_back(o);
                    rec_addr.push_back(a);
                    rec_wdata.push_back(d);
                    rec_strb.push_back(s[3:0]);
                    rec_rdata.push_back(r);
                    rec_resp.push_back(p[1:0]);
                    rec_name.push_back(nm);
                end
            end
            $fclose(fd);
        end
        if (rec_addr.size() == 0) begin
            $display("no stimulus records were loaded");
            errors++;
        end
    endtask

    task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb,
                             output logic [1:0] resp);
        logic [1:0] delay;
        @(posedge aclk);
        lsu_awvalid <= 1'b1;
        lsu_awaddr  <= addr;
        lsu_wvalid  <= 1'b1;
        lsu_wdata   <= data;
        lsu_wstrb   <= strb;
        @(negedge aclk);
        while (!(lsu_awready && lsu_wready)) @(negedge aclk);
        @(posedge aclk);
        lsu_awvalid <= 1'b0;
        lsu_wvalid  <= 1'b0;
        lcg_state = lcg_next(lcg_state);
        delay = lcg_state[17:16];
        repeat (delay) @(posedge aclk);
        lsu_bready <= 1'b1;
        @(negedge aclk);
        while (!lsu_bvalid) @(negedge aclk);
        resp = lsu_bresp;
        @(posedge aclk);
        lsu_bready <= 1'b0;
    endtask

    task automatic read_txn(input logic from_ifu, input logic stall, input addr_t addr,
                            input logic [8*24-1:0] name, output data_t data,
                            output logic [1:0] resp);
        logic [1:0] delay;
        @(posedge aclk);
        if (from_ifu) begin
            ifu_arvalid <= 1'b1;
            ifu_araddr  <= addr;
        end else begin
            lsu_arvalid <= 1'b1;
            lsu_araddr  <= addr;
        end
        // ifu waits while the lsu holds the grant
        if (stall) begin
            repeat (3) begin
                @(negedge aclk);
                check_value(name, 32'd0, {31'd0, ifu_arready});
            end
            @(posedge aclk);
            inst_fetch_flag <= 1'b1;
            mem_access_flag <= 1'b0;
        end
        @(negedge aclk);
        while (!(from_ifu ? ifu_arready : lsu_arready)) @(negedge aclk);
        @(posedge aclk);
        ifu_arvalid <= 1'b0;
        lsu_arvalid <= 1'b0;
        lcg_state = lcg_next(lcg_state);
        delay = lcg_state[17:16];
        repeat (delay) @(posedge aclk);
        if (from_ifu) ifu_rready <= 1'b1;
        else lsu_rready <= 1'b1;
        @(negedge aclk);
        while (!(from_ifu ? ifu_rvalid : lsu_rvalid)) @(negedge aclk);
        data = from_ifu ? ifu_rdata : lsu_rdata;
        resp = from_ifu ? ifu_rresp : lsu_rresp;
        @(posedge aclk);
        ifu_rready <= 1'b0;
        lsu_rready <= 1'b0;
    endtask

    task automatic run_record(input int i);
        logic [8*24-1:0] nm;
        logic [1:0] rsp;
        logic [9:0] idx;
        logic       in_pmem;
        data_t      got;
        data_t      mask;
        int         pulses_before;
        nm      = rec_name[i];
        idx     = rec_addr[i][11:2];
        in_pmem = (rec_addr[i] >= pmem_base) && ((rec_addr[i] - pmem_base) < pmem_size);
        if (rec_master[i] == "lsu" && !on_lsu) begin
            @(posedge aclk);
            mem_access_flag <= 1'b1;
            inst_fetch_flag <= 1'b0;
            on_lsu = 1'b1;
        end
        if (rec_op[i] == "wr") begin
            pulses_before = uart_pulses;
            write_txn(rec_addr[i], rec_wdata[i], rec_strb[i], rsp);
            check_value(nm, {30'd0, rec_resp[i]}, {30'd0, rsp});
            if (in_pmem && rec_resp[i] == 2'd0) begin
                mask = {{8{rec_strb[i][3]}}, {8{rec_strb[i][2]}},
                        {8{rec_strb[i][1]}}, {8{rec_strb[i][0]}}};
                model[idx] = (model[idx] & ~mask) | (rec_wdata[i] & mask);
            end
            if (rec_addr[i] == uart_base && rec_resp[i] == 2'd0) begin
                check_value(nm, 32'd1, uart_pulses - pulses_before);
                check_value(nm, {24'd0, rec_wdata[i][7:0]}, {24'd0, uart_last});
            end
        end else begin
            read_txn(rec_master[i] == "ifu", rec_master[i] == "ifu" && on_lsu, rec_addr[i],
                     nm, got, rsp);
            if (rec_master[i] == "ifu") on_lsu = 1'b0;
            check_value(nm, {30'd0, rec_resp[i]}, {30'd0, rsp});
            if (rec_op[i] == "rt") begin
                // mtime only counts up
                check_value(nm, 32'd1, {31'd0, got > last_timer});
                last_timer = got;
            end else begin
                check_value(nm, rec_rdata[i], got);
                if (in_pmem && rec_resp[i] == 2'd0) check_value(nm, model[idx], got);
            end
        end
    endtask

    initial begin
        areset_n        <= 1'b1;
        inst_fetch_flag <= 1'b0;
        mem_access_flag <= 1'b0;
        ifu_arvalid     <= 1'b0;
        ifu_araddr      <= '0;
        ifu_arprot      <= '0;
        ifu_rready      <= 1'b0;
        lsu_awvalid     <= 1'b0;
        lsu_awaddr      <= '0;
        lsu_awprot      <= '0;
        lsu_wvalid      <= 1'b0;
        lsu_wdata       <= '0;
        lsu_wstrb       <= '0;
        lsu_bready      <= 1'b0;
        lsu_arvalid     <= 1'b0;
        lsu_araddr      <= '0;
        lsu_arprot      <= '0;
        lsu_rready      <= 1'b0;
        load_golden();
        cycle_limit = 20 * rec_addr.size() + 100;
        repeat (8) @(posedge aclk);
        areset_n <= 1'b0;
        for (int i = 0; i < rec_addr.size(); i++) begin
            run_record(i);
        end
        repeat (4) @(posedge aclk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
src/soc_bus_pkg.sv
src/axi_lite_if.sv
src/pmem_arbiter.sv
src/mmio_xbar.sv
src/pmem_ram.sv
src/uart_tx_reg.sv
src/clint_timer.sv
src/soc_mem_top.sv
tb/soc_mem_chk.sv
tb/tb_soc_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the memory subsystem testbench with Verilator, runs it, checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_soc_mem -o sim_soc_mem -f build.f

./obj_dir/sim_soc_mem | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb/soc_mem_golden.txt */
# master op addr wdata strb exp_rdata exp_resp test_name
# op wr is a write, rd a read, rt a timer read that must exceed the previous rt value
lsu wr 80000000 11223344 f 00000000 0 pmem_full_write
lsu wr 80000000 aabbccdd 5 00000000 0 pmem_strobe_write
lsu rd 80000000 00000000 0 11bb33dd 0 pmem_merge_read
lsu wr 80000004 00000013 f 00000000 0 pmem_word1_write
lsu wr 80000ffc deadbeef f 00000000 0 pmem_last_write
ifu rd 80000000 00000000 0 11bb33dd 0 ifu_fetch_stall
ifu rd 80000004 00000000 0 00000013 0 ifu_fetch_word1
ifu rd 80000ffc 00000000 0 deadbeef 0 ifu_fetch_last
lsu wr a00003f8 00000141 f 00000000 0 uart_write
lsu rd a00003f8 00000000 0 00000000 3 uart_read_err
lsu rt a0000048 00000000 0 00000000 0 clint_lo_first
lsu rt a0000048 00000000 0 00000000 0 clint_lo_second
lsu rd a000004c 00000000 0 00000000 0 clint_hi_read
lsu rd 90000000 00000000 0 00000000 3 unmapped_read
lsu wr 90000000 12345678 f 00000000 3 unmapped_write
lsu wr a0000048 00000001 f 00000000 3 clint_write_err
lsu rd 80001000 00000000 0 00000000 3 pmem_past_end
lsu rd 80000004 00000000 0 00000013 0 pmem_after_err
lsu wr 80000008 0000a55a 3 00000000 0 pmem_half_write
ifu rd 80000008 00000000 0 0000a55a 0 ifu_fetch_half
